/* lvds_tx.f */
+incdir+.
lvds_tx_pkg.sv
clock_generator_s8.sv
lvds_tx_regs.sv
lvds_tx_word_source.sv
lvds_tx_serializer.sv
lvds_tx_top.sv
lvds_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lvds_tx testbench with Verilator

verilator --binary --timing -f lvds_tx.f --top-module lvds_tx_tb -o lvds_tx_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/lvds_tx_sim > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* lvds_tx_tb.sv */
`timescale 1ns/100ps

`include "lvds_tx_defines.svh"

module lvds_tx_tb
  import lvds_tx_pkg::*;
();

  localparam int SEED = 59;
  localparam int MAX_STEPS = 64;
  localparam real CLK_NS = 4.0;
  typedef enum int {OP_WRITE, OP_READ, OP_LOCK, OP_TRAIN, OP_SEND, OP_GAP, OP_CHECK,
                    OP_UFLOW, OP_UNLOCK} op_t;

  logic clkin = 1'b0;
  logic arst_n = 1'b0;
  apb_addr_t paddr = '0;
  logic psel = 1'b0;
  logic penable = 1'b0;
  logic pwrite = 1'b0;
  apb_data_t pwdata = '0;
  apb_data_t prdata;
  logic pready;
  logic pslverr;
  tx_word_t tx_data = '0;
  logic tx_valid = 1'b0;
  logic tx_ready;
  logic [`LVDS_TX_LANES-1:0] tx_serial;
  logic bufpll_lckd;

  op_t step_op [MAX_STEPS];          // stimulus table
  apb_addr_t step_addr [MAX_STEPS];
  apb_data_t step_data [MAX_STEPS];
  logic step_err [MAX_STEPS];        // expected pslverr
  int nsteps = 0;
  int cyc = 0;                       // rising edges seen
  int release_cyc = 0;               // edge count at lock-reset release
  int lock_cyc = -1;                 // edge count when lock was first seen
  int uf_total = 0;                  // idle words counted in data mode
  int uf_base = 0;                   // uf_total at the last clear
  int uf_sampled = 0;                // uf_total at the last apb sample
  logic uf_pending = 1'b0;           // idle strobe in the current cycle
  int err_cnt = 0;
  logic pll_reset_shadow = 1'b0;
  logic enable_shadow = 1'b0;        // ctrl bits as last written
  logic train_shadow = 1'b1;
  logic lckd_prev = 1'b0;
  int cap_start[$];                  // captured words, keyed by first-bit cycle
  tx_word_t cap_word[$];
  int exp_start[$];                  // expected words from the handshakes
  tx_word_t exp_word[$];
  int lock_idx = 0;                  // negedges since lock
  int bit_cnt = 0;
  int word_start = 0;
  tx_word_t asm_word = '0;
  lane_word_t cur_pattern = `LVDS_TX_PATTERN_RESET;

  lvds_tx_top u_dut (
    .clkin(clkin), .arst_n(arst_n),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .tx_serial(tx_serial), .bufpll_lckd(bufpll_lckd)
  );

  always #(CLK_NS / 2.0) clkin = ~clkin;

  always @(posedge clkin) cyc <= cyc + 1;

  // the DUT counts an idle strobe at the edge that closes it
  always @(posedge clkin) begin
    if (uf_pending) uf_total <= uf_total + 1;
  end

  // lanes are stable at the falling edge, strobe follows lock by one cycle
  always @(negedge clkin) begin
    if (bufpll_lckd && !lckd_prev) lock_cyc = cyc;
    lckd_prev = bufpll_lckd;
    // strobe every LVDS_TX_S cycles from one cycle after lock
    uf_pending = bufpll_lckd && (lock_idx % `LVDS_TX_S == 1) && enable_shadow
                 && !train_shadow && !tx_valid;
    if (!bufpll_lckd) begin
      lock_idx = 0;
      bit_cnt = 0;
    end else begin
      if (lock_idx >= 2) begin   // first bit of the first word
        if (bit_cnt == 0) word_start = cyc;
        for (int l = 0; l < `LVDS_TX_LANES; l++) begin
          asm_word[l*`LVDS_TX_S +: `LVDS_TX_S] =
            {asm_word[l*`LVDS_TX_S +: `LVDS_TX_S-1], tx_serial[l]};
        end
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == `LVDS_TX_S) begin
          cap_start.push_back(word_start);
          cap_word.push_back(asm_word);
          bit_cnt = 0;
        end
      end
      lock_idx = lock_idx + 1;
    end
  end

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_reg(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp) report_fail($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_word(input tx_word_t got, input tx_word_t exp, input string what);
    if (got !== exp) report_fail($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_fail($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic add_step(input op_t op, input apb_addr_t a, input apb_data_t d,
                          input logic e);
    step_op[nsteps] = op;
    step_addr[nsteps] = a;
    step_data[nsteps] = d;
    step_err[nsteps] = e;
    nsteps++;
  endtask

  // two-cycle apb access, returns 0.5 ns after the access edge
  task automatic apb_access(input logic wr, input apb_addr_t a, input apb_data_t d,
                            output apb_data_t rd, output logic err);
    @(posedge clkin);
    #0.5;
    psel = 1'b1;
    pwrite = wr;
    paddr = a;
    pwdata = d;
    @(posedge clkin);
    #0.5;
    penable = 1'b1;
    @(negedge clkin);
    rd = prdata;
    err = pslverr;
    uf_sampled = uf_total;       // count the DUT holds at this sample
    check_bit(pready, 1'b1, "pready");
    @(posedge clkin);
    #0.5;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t a, input apb_data_t d, input logic exp_err);
    apb_data_t rd;
    logic err;
    apb_access(1'b1, a, d, rd, err);
    check_bit(err, exp_err, $sformatf("pslverr on write to %h", a));
    if (a == `LVDS_TX_ADDR_UNDERFLOW) uf_base = uf_total;   // cleared at the access edge
    if (a == `LVDS_TX_ADDR_PATTERN) cur_pattern = d[`LVDS_TX_S-1:0];
    if (a == `LVDS_TX_ADDR_CTRL) begin
      if (pll_reset_shadow && !d[2]) release_cyc = cyc;
      pll_reset_shadow = d[2];
      enable_shadow = d[0];
      train_shadow = d[1];
    end
  endtask

  task automatic apb_read(input apb_addr_t a, input apb_data_t exp, input logic exp_err);
    apb_data_t rd;
    logic err;
    apb_access(1'b0, a, '0, rd, err);
    check_reg(rd, exp, $sformatf("read of %h", a));
    check_bit(err, exp_err, $sformatf("pslverr on read of %h", a));
  endtask

  task automatic read_underflow();
    apb_data_t rd;
    logic err;
    apb_access(1'b0, `LVDS_TX_ADDR_UNDERFLOW, '0, rd, err);
    check_reg(rd, apb_data_t'(uf_sampled - uf_base), "underflow count");
    check_bit(err, 1'b0, "pslverr on underflow read");
  endtask

  // offers one word, or an idle gap, and logs where it must appear
  task automatic send_word(input logic valid, input tx_word_t d);
    int waits;
    waits = 0;
    @(posedge clkin);
    #0.5;
    tx_valid = valid;
    tx_data = d;
    @(negedge clkin);
    while (!tx_ready) begin
      waits++;
      if (waits > 4 * `LVDS_TX_S) report_fail("tx_ready never rose for a data word");
      @(negedge clkin);
    end
    @(posedge clkin);
    #0.5;
    exp_start.push_back(cyc);
    exp_word.push_back(valid ? d : '0);
    tx_valid = 1'b0;
  endtask

  task automatic check_words();
    int last;
    int waits;
    bit found;
    last = exp_start[exp_start.size()-1];
    waits = 0;
    while (cap_start.size() == 0 || cap_start[cap_start.size()-1] < last) begin
      waits++;
      if (waits > 8 * `LVDS_TX_S) report_fail("serial words were not captured in time");
      @(negedge clkin);
    end
    foreach (exp_start[i]) begin
      found = 0;
      foreach (cap_start[j]) begin
        if (cap_start[j] == exp_start[i]) begin
          found = 1;
          check_word(cap_word[j], exp_word[i], $sformatf("word at cycle %0d", exp_start[i]));
        end
      end
      if (!found) report_fail($sformatf("no serial word started at cycle %0d", exp_start[i]));
    end
    exp_start.delete();
    exp_word.delete();
  endtask

  task automatic check_training(input int n);
    int first;
    int cnt;
    first = cyc + 1;
    cnt = 0;
    while (cnt < n) begin
      @(negedge clkin);
      check_bit(tx_ready, 1'b0, "tx_ready while training");
      cnt = 0;
      foreach (cap_start[j]) begin
        if (cap_start[j] >= first) begin
          cnt++;
          check_word(cap_word[j], {`LVDS_TX_LANES{cur_pattern}}, "training word");
        end
      end
    end
  endtask

  task automatic wait_lock();
    while (!bufpll_lckd) @(negedge clkin);
    #0.1;                        // lock_cyc is taken at the same falling edge
    check_reg(apb_data_t'(lock_cyc - release_cyc), `LVDS_TX_LOCK_CYCLES, "lock latency");
  endtask

  task automatic check_unlocked(input int n);
    @(negedge clkin);
    @(negedge clkin);
    check_bit(bufpll_lckd, 1'b0, "lock after pll_reset");
    for (int i = 0; i < n; i++) begin
      @(negedge clkin);
      check_bit(bufpll_lckd, 1'b0, "lock while in pll_reset");
      check_bit(tx_ready, 1'b0, "tx_ready while in pll_reset");
      check_bit(|tx_serial, 1'b0, "tx_serial while in pll_reset");
    end
  endtask

  initial begin
    real limit_ns;
    wait (arst_n);
    limit_ns = nsteps * 20 * 8 * CLK_NS + `LVDS_TX_LOCK_CYCLES * CLK_NS;
    #(limit_ns);
    $display("timeout: the test did not finish within %0.1f ns", limit_ns);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    add_step(OP_READ, `LVDS_TX_ADDR_CTRL, 32'h2, 1'b0);
    add_step(OP_READ, `LVDS_TX_ADDR_PATTERN, 32'hA5, 1'b0);
    add_step(OP_READ, `LVDS_TX_ADDR_STATUS, 32'h0, 1'b0);
    add_step(OP_READ, 4'h2, 32'h0, 1'b1);                   // unmapped
    add_step(OP_WRITE, `LVDS_TX_ADDR_CTRL, 32'h3, 1'b0);    // enable, train
    add_step(OP_LOCK, '0, '0, 1'b0);
    add_step(OP_READ, `LVDS_TX_ADDR_STATUS, 32'h1, 1'b0);
    add_step(OP_WRITE, `LVDS_TX_ADDR_PATTERN, apb_data_t'($urandom() & 32'hFF), 1'b0);
    add_step(OP_TRAIN, '0, 32'd4, 1'b0);
    add_step(OP_WRITE, `LVDS_TX_ADDR_CTRL, 32'h1, 1'b0);    // data mode
    for (int i = 0; i < 6; i++) add_step(OP_SEND, '0, $urandom(), 1'b1);
    for (int i = 0; i < 3; i++) add_step(OP_GAP, '0, '0, 1'b0);
    add_step(OP_SEND, '0, $urandom(), 1'b1);
    add_step(OP_CHECK, '0, '0, 1'b0);
    add_step(OP_UFLOW, `LVDS_TX_ADDR_UNDERFLOW, '0, 1'b0);
    add_step(OP_WRITE, `LVDS_TX_ADDR_UNDERFLOW, 32'h0, 1'b1);
    add_step(OP_UFLOW, `LVDS_TX_ADDR_UNDERFLOW, '0, 1'b0);
    add_step(OP_WRITE, `LVDS_TX_ADDR_STATUS, 32'h0, 1'b1);  // read only
    add_step(OP_WRITE, `LVDS_TX_ADDR_CTRL, 32'h5, 1'b0);    // pll_reset
    add_step(OP_UNLOCK, '0, 32'd20, 1'b0);
    add_step(OP_WRITE, `LVDS_TX_ADDR_CTRL, 32'h1, 1'b0);
    add_step(OP_LOCK, '0, '0, 1'b0);
    for (int i = 0; i < 3; i++) add_step(OP_SEND, '0, $urandom(), 1'b1);
    add_step(OP_CHECK, '0, '0, 1'b0);

    repeat (16) @(posedge clkin);
    #0.5;
    arst_n = 1'b1;
    release_cyc = cyc;
    @(negedge clkin);
    check_bit(tx_ready, 1'b0, "tx_ready after reset");
    check_bit(|tx_serial, 1'b0, "tx_serial after reset");
    check_bit(bufpll_lckd, 1'b0, "lock after reset");
    check_bit(pslverr, 1'b0, "pslverr after reset");

    for (int s = 0; s < nsteps; s++) begin
      case (step_op[s])
        OP_WRITE:  apb_write(step_addr[s], step_data[s], step_err[s]);
        OP_READ:   apb_read(step_addr[s], step_data[s], step_err[s]);
        OP_LOCK:   wait_lock();
        OP_TRAIN:  check_training(int'(step_data[s]));
        OP_SEND:   send_word(1'b1, step_data[s]);
        OP_GAP:    send_word(1'b0, '0);
        OP_CHECK:  check_words();
        OP_UFLOW:  read_underflow();
        OP_UNLOCK: check_unlocked(int'(step_data[s]));
        default:   report_fail("unknown table step");
      endcase
    end

    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* lvds_tx_top.sv */
`timescale 1ns/100ps

`include "lvds_tx_defines.svh"

module lvds_tx_top
  import lvds_tx_pkg::*;
(
  input  logic                      clkin,     // bit-rate clock, also the apb clock
  input  logic                      arst_n,
  // apb slave
  input  apb_addr_t                 paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  apb_data_t                 pwdata,
  output apb_data_t                 prdata,
  output logic                      pready,
  output logic                      pslverr,
  // user data
  input  tx_word_t                  tx_data,
  input  logic                      tx_valid,
  output logic                      tx_ready,
  // serial lanes and lock
  output logic [`LVDS_TX_LANES-1:0] tx_serial,
  output logic                      bufpll_lckd
);

  logic       enable;
  logic       train;
  logic       pll_reset;
  lane_word_t pattern;
  logic       serdesstrobe;  // word boundary, used as a clock enable
  tx_word_t   word;
  logic       load;
  logic       underflow;

  clock_generator_s8 u_clkgen (
    .clkin        (clkin),
    .arst_n       (arst_n),
    .pll_reset    (pll_reset),
    .serdesstrobe (serdesstrobe),
    .bufpll_lckd  (bufpll_lckd)
  );

  lvds_tx_regs u_regs (
    .clkin     (clkin),
    .arst_n    (arst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .locked    (bufpll_lckd),
    .underflow (underflow),
    .enable    (enable),
    .train     (train),
    .pll_reset (pll_reset),
    .pattern   (pattern)
  );

  lvds_tx_word_source u_source (
    .serdesstrobe (serdesstrobe),
    .locked       (bufpll_lckd),
    .enable       (enable),
    .train        (train),
    .pattern      (pattern),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .word         (word),
    .load         (load),
    .underflow    (underflow)
  );

  lvds_tx_serializer u_serializer (
    .clkin     (clkin),
    .arst_n    (arst_n),
    .load      (load),
    .word      (word),
    .tx_serial (tx_serial)
  );

endmodule

/* lvds_tx_serializer.sv */
`timescale 1ns/100ps

`include "lvds_tx_defines.svh"

module lvds_tx_serializer
  import lvds_tx_pkg::*;
(
  input  logic                      clkin,
  input  logic                      arst_n,
  input  logic                      load,      // parallel load, else shift
  input  tx_word_t                  word,      // lane n in byte n
  output logic [`LVDS_TX_LANES-1:0] tx_serial  // registered lane msbs
);

  for (genvar lane = 0; lane < `LVDS_TX_LANES; lane++) begin : g_lane
    lane_word_t shreg;  // bits still to go out on this lane

    always_ff @(posedge clkin or negedge arst_n) begin
      if (!arst_n) begin
        shreg <= '0;    // lanes start low
      end else if (load) begin
        shreg <= word[lane*`LVDS_TX_S +: `LVDS_TX_S];
      end else begin
        shreg <= {shreg[`LVDS_TX_S-2:0], 1'b0};  // msb first, zero fill
      end
    end

    assign tx_serial[lane] = shreg[`LVDS_TX_S-1];
  end

endmodule

/* lvds_tx_word_source.sv */
`timescale 1ns/100ps

`include "lvds_tx_defines.svh"

module lvds_tx_word_source
  import lvds_tx_pkg::*;
(
  input  logic       serdesstrobe,  // word boundary from the clock generator
  input  logic       locked,
  input  logic       enable,
  input  logic       train,
  input  lane_word_t pattern,       // training byte
  input  tx_word_t   tx_data,
  input  logic       tx_valid,
  output logic       tx_ready,
  output tx_word_t   word,          // next word for the serializer
  output logic       load,          // serializer parallel load
  output logic       underflow      // idle word sent in data mode
);

  logic data_mode;    // locked, enabled and not training
  logic take;         // handshake this cycle
  tx_word_t pattern_word;

  assign pattern_word = {`LVDS_TX_LANES{pattern}};  // same byte on every lane

  assign data_mode = locked && enable && !train;
  assign tx_ready  = serdesstrobe && data_mode;     // only on a word boundary
  assign take      = tx_ready && tx_valid;

  // strobe, or every cycle while unlocked so the lanes flush to zero
  assign load = serdesstrobe || !locked;

  always_comb begin
    if (!locked || !enable) begin
      word = '0;               // disabled or unlocked, lanes carry zeros
    end else if (train) begin
      word = pattern_word;
    end else if (take) begin
      word = tx_data;
    end else begin
      word = '0;               // idle word
    end
  end

  // one pulse per idle word, held off while training or disabled
  assign underflow = tx_ready && !tx_valid;

endmodule

/* lvds_tx_regs.sv */
`timescale 1ns/100ps

`include "lvds_tx_defines.svh"

module lvds_tx_regs
  import lvds_tx_pkg::*;
(
  input  logic       clkin,
  input  logic       arst_n,
  input  apb_addr_t  paddr,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  input  logic       locked,     // lock state for STATUS
  input  logic       underflow,  // one pulse per idle word in data mode
  output logic       enable,
  output logic       train,
  output logic       pll_reset,
  output lane_word_t pattern
);

  localparam int UFLOW_W = 16;     // underflow counter width

  logic access;                    // apb access phase
  logic wr_access;
  logic sel_ctrl;
  logic sel_pattern;
  logic sel_status;
  logic sel_uflow;
  logic mapped;                    // address hits a register
  logic [UFLOW_W-1:0] uflow_cnt;   // idle words sent in data mode
  apb_data_t rd_data;

  assign access    = psel && penable;
  assign wr_access = access && pwrite;

  // full 4-bit compare, misaligned addresses fall out as unmapped
  assign sel_ctrl    = (paddr == `LVDS_TX_ADDR_CTRL);
  assign sel_pattern = (paddr == `LVDS_TX_ADDR_PATTERN);
  assign sel_status  = (paddr == `LVDS_TX_ADDR_STATUS);
  assign sel_uflow   = (paddr == `LVDS_TX_ADDR_UNDERFLOW);
  assign mapped      = sel_ctrl || sel_pattern || sel_status || sel_uflow;

  // control and pattern registers
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      enable    <= 1'b0;
      train     <= 1'b1;                    // start out sending the pattern
      pll_reset <= 1'b0;
      pattern   <= `LVDS_TX_PATTERN_RESET;
    end else if (wr_access) begin
      if (sel_ctrl) begin
        enable    <= pwdata[0];
        train     <= pwdata[1];
        pll_reset <= pwdata[2];
      end
      if (sel_pattern) begin
        pattern <= pwdata[`LVDS_TX_S-1:0];
      end
    end
  end

  // underflow counter, write clears and takes priority over a new pulse
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      uflow_cnt <= '0;
    end else if (wr_access && sel_uflow) begin
      uflow_cnt <= '0;
    end else if (underflow && (uflow_cnt != '1)) begin
      uflow_cnt <= uflow_cnt + 1'b1;        // saturates at all ones
    end
  end

  // read mux, zero for unmapped addresses
  always_comb begin
    rd_data = '0;
    case (1'b1)
      sel_ctrl:    rd_data[2:0] = {pll_reset, train, enable};
      sel_pattern: rd_data[`LVDS_TX_S-1:0] = pattern;
      sel_status:  rd_data[0] = locked;
      sel_uflow:   rd_data[UFLOW_W-1:0] = uflow_cnt;
      default:     rd_data = '0;
    endcase
  end

  assign prdata = (psel && !pwrite) ? rd_data : '0;
  assign pready = 1'b1;  // no wait states

  // error on unmapped access or a write to STATUS or UNDERFLOW
  assign pslverr = access && (!mapped || (pwrite && (sel_status || sel_uflow)));

endmodule

/* clock_generator_s8.sv */
`timescale 1ns/100ps

`include "lvds_tx_defines.svh"

module clock_generator_s8
  import lvds_tx_pkg::*;
(
  input  logic clkin,         // bit-rate clock
  input  logic arst_n,
  input  logic pll_reset,     // holds the generator out of lock
  output logic serdesstrobe,  // one cycle in every LVDS_TX_S, word boundary
  output logic bufpll_lckd    // lock indication
);

  localparam int PHASE_W = $clog2(`LVDS_TX_S);  // bits in the word phase counter
  localparam lock_cnt_t LOCK_LAST = lock_cnt_t'(`LVDS_TX_LOCK_CYCLES - 1);

  clkgen_state_t state;      // current lock state
  clkgen_state_t state_nxt;
  lock_cnt_t lock_cnt;       // edges seen since reset release
  logic [PHASE_W-1:0] phase; // position inside the word

  // next lock state, pll_reset wins over everything
  always_comb begin
    state_nxt = state;
    if (pll_reset) begin
      state_nxt = RESET;
    end else begin
      case (state)
        RESET:   state_nxt = SETTLE;                          // first counted edge
        SETTLE:  if (lock_cnt == LOCK_LAST) state_nxt = LOCKED;
        LOCKED:  state_nxt = LOCKED;
        default: state_nxt = RESET;
      endcase
    end
  end

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      state    <= RESET;
      lock_cnt <= '0;
      phase    <= '0;
    end else begin
      state <= state_nxt;
      if (state_nxt == RESET) begin
        lock_cnt <= '0;
      end else if (state == RESET) begin
        lock_cnt <= lock_cnt_t'(1);   // edge leaving RESET counts as the first
      end else if (state == SETTLE) begin
        lock_cnt <= lock_cnt + 1'b1;
      end
      // phase wraps to zero on the edge after lock, giving the first strobe
      if (state == SETTLE && state_nxt == LOCKED) begin
        phase <= '1;
      end else if (state == LOCKED) begin
        phase <= phase + 1'b1;        // modulo LVDS_TX_S, power of two
      end
    end
  end

  assign bufpll_lckd  = (state == LOCKED);
  assign serdesstrobe = (state == LOCKED) && (phase == '0);  // drops with lock

endmodule

/* lvds_tx_pkg.sv */
`include "lvds_tx_defines.svh"

package lvds_tx_pkg;

  // one lane's word, shifted out msb first
  typedef logic [`LVDS_TX_S-1:0] lane_word_t;

  // all lanes side by side, lane 0 in the low byte
  typedef logic [`LVDS_TX_LANES*`LVDS_TX_S-1:0] tx_word_t;

  // apb bus widths
  typedef logic [3:0] apb_addr_t;   // byte address, four registers
  typedef logic [31:0] apb_data_t;  // read and write data

  // settle counter, wide enough for LVDS_TX_LOCK_CYCLES
  typedef logic [6:0] lock_cnt_t;

  // stand-in for pll lock acquisition
  typedef enum logic [1:0] {
    RESET,   // held in reset, no lock
    SETTLE,  // counting toward lock
    LOCKED   // lock reported, strobe running
  } clkgen_state_t;

endpackage

/* lvds_tx_defines.svh */
`ifndef LVDS_TX_DEFINES_SVH
`define LVDS_TX_DEFINES_SVH

// lane and word geometry
`define LVDS_TX_LANES 4          // serial lanes driven in parallel
`define LVDS_TX_S 8              // serdes factor, bits per lane word

// clkin cycles from lock-reset release to lock
`define LVDS_TX_LOCK_CYCLES 64

// apb byte addresses
`define LVDS_TX_ADDR_CTRL 4'h0       // enable, train, pll_reset
`define LVDS_TX_ADDR_PATTERN 4'h4    // training byte
`define LVDS_TX_ADDR_STATUS 4'h8     // lock state, read only
`define LVDS_TX_ADDR_UNDERFLOW 4'hC  // idle word count, read only

// training byte after reset, same on every lane
`define LVDS_TX_PATTERN_RESET 8'hA5

`endif
